/* verilog/mul_pkg.sv */
package mul_pkg;

  // Operation select on every request
  typedef enum logic [1:0] {
    MUL_UU = 2'd0,                      // Unsigned by unsigned
    MUL_SS = 2'd1,                      // Signed by signed
    MUL_SU = 2'd2                       // Signed A by unsigned B
  } mul_op_e;

  // Lane sequencer states
  typedef enum logic [1:0] {
    LANE_IDLE = 2'd0,                   // Waiting for a req toggle
    LANE_CALC = 2'd1,                   // One shift-add step per edge
    LANE_DONE = 2'd2                    // Product held until collected
  } lane_state_e;

endpackage

/* verilog/mul_abp_if.sv */
interface mul_abp_if #(
  parameter int WIDTH = 32
);

  logic [WIDTH-1:0]   a;                // Operand A
  logic [WIDTH-1:0]   b;                // Operand B
  mul_pkg::mul_op_e   op;               // Operation type
  logic               req;              // Toggles per new request
  logic               ack;              // Follows req when product ready
  logic [2*WIDTH-1:0] product;          // Full double-width result
  logic               free;             // Lane idle and link settled
  logic               take;             // Toggled once product copied

  // Dispatcher side
  modport issue (
    output a,
    output b,
    output op,
    output req,
    input  free
  );

  // Multiplier lane side
  modport unit (
    input  a,
    input  b,
    input  op,
    input  req,
    input  take,
    output ack,
    output product,
    output free
  );

  // Collector side
  modport drain (
    input  ack,
    input  product,
    output take
  );

endinterface

/* verilog/mul_dispatch.sv */
module mul_dispatch #(
  parameter int WIDTH     = 32,
  parameter int NUM_LANES = 4
) (
  input  logic             sys_clock_i,
  input  logic             sys_reset_i,
  input  logic             in_req_i,                // External request level
  output logic             in_ack_o,                // Follows in_req_i on accept
  input  logic [WIDTH-1:0] a_i,
  input  logic [WIDTH-1:0] b_i,
  input  mul_pkg::mul_op_e op_i,
  mul_abp_if.issue         lane_if_o [NUM_LANES]    // One link per lane
);

  localparam int PTR_W = $clog2(NUM_LANES);

  logic [PTR_W-1:0]     ptr_q;                      // Next lane to issue to
  logic [NUM_LANES-1:0] req_q;                      // Req level per lane
  logic [NUM_LANES-1:0] lane_free;                  // Gathered free flags
  logic [WIDTH-1:0]     a_q [NUM_LANES];            // Held operand A per lane
  logic [WIDTH-1:0]     b_q [NUM_LANES];            // Held operand B per lane
  mul_pkg::mul_op_e     op_q [NUM_LANES];           // Held operation per lane
  logic                 accept;                     // Take external request now

  for (genvar g = 0; g < NUM_LANES; g++) begin : g_lane
    assign lane_free[g]     = lane_if_o[g].free;
    assign lane_if_o[g].a   = a_q[g];
    assign lane_if_o[g].b   = b_q[g];
    assign lane_if_o[g].op  = op_q[g];
    assign lane_if_o[g].req = req_q[g];
  end

  // Only the lane at the pointer may take it, so issue order matches drain order
  assign accept = (in_req_i != in_ack_o) && lane_free[ptr_q];

  always_ff @(posedge sys_clock_i) begin
    if (sys_reset_i) begin
      ptr_q    <= '0;
      req_q    <= '0;
      in_ack_o <= 1'b0;
    end else if (accept) begin
      req_q[ptr_q] <= ~req_q[ptr_q];                // New request to lane
      in_ack_o     <= ~in_ack_o;                    // Close external handshake
      if (ptr_q == PTR_W'(NUM_LANES - 1)) begin
        ptr_q <= '0;                                // Wrap round-robin
      end else begin
        ptr_q <= ptr_q + 1'b1;
      end
    end
  end

  // Operand registers stay put while the lane works on them
  always_ff @(posedge sys_clock_i) begin
    for (int i = 0; i < NUM_LANES; i++) begin
      if (accept && (ptr_q == PTR_W'(i))) begin
        a_q[i]  <= a_i;
        b_q[i]  <= b_i;
        op_q[i] <= op_i;
      end
    end
  end

endmodule

/* verilog/mul_lane.sv */
module mul_lane #(
  parameter int WIDTH = 32
) (
  input  logic    sys_clock_i,
  input  logic    sys_reset_i,
  mul_abp_if.unit lane_if_i                         // Request and result link
);

  localparam int CNT_W = $clog2(WIDTH + 1);

  mul_pkg::lane_state_e state_q;                    // Sequencer state
  logic [CNT_W-1:0]     count_q;                    // Steps left (WIDTH down to 0)
  logic                 ack_q;                      // Also the last served req level
  logic [2*WIDTH-1:0]   a_shift_q;                  // Magnitude of A, shifted left
  logic [WIDTH-1:0]     b_shift_q;                  // Magnitude of B, shifted right
  logic [2*WIDTH-1:0]   acc_q;                      // Unsigned partial sum
  logic                 neg_q;                      // Result needs negation
  logic [2*WIDTH-1:0]   product_q;                  // Presented product

  logic                 a_signed;
  logic                 b_signed;
  logic                 a_is_neg;
  logic                 b_is_neg;
  logic [WIDTH-1:0]     a_mag;
  logic [WIDTH-1:0]     b_mag;
  logic [2*WIDTH-1:0]   acc_next;
  logic                 start;
  logic                 step;
  logic                 finish;

  assign a_signed = (lane_if_i.op == mul_pkg::MUL_SS) || (lane_if_i.op == mul_pkg::MUL_SU);
  assign b_signed = (lane_if_i.op == mul_pkg::MUL_SS);
  assign a_is_neg = a_signed && lane_if_i.a[WIDTH-1];
  assign b_is_neg = b_signed && lane_if_i.b[WIDTH-1];
  assign a_mag    = a_is_neg ? (~lane_if_i.a + 1'b1) : lane_if_i.a;   // Two's complement abs
  assign b_mag    = b_is_neg ? (~lane_if_i.b + 1'b1) : lane_if_i.b;

  assign acc_next = b_shift_q[0] ? (acc_q + a_shift_q) : acc_q;       // Add when bit set

  assign start  = (state_q == mul_pkg::LANE_IDLE) && (lane_if_i.req != ack_q);
  assign step   = (state_q == mul_pkg::LANE_CALC) && (count_q != '0);
  assign finish = (state_q == mul_pkg::LANE_CALC) && (count_q == '0);

  always_ff @(posedge sys_clock_i) begin
    if (sys_reset_i) begin
      state_q <= mul_pkg::LANE_IDLE;
      count_q <= '0;
      ack_q   <= 1'b0;
    end else begin
      case (state_q)
        mul_pkg::LANE_IDLE: begin
          if (start) begin
            state_q <= mul_pkg::LANE_CALC;
            count_q <= CNT_W'(WIDTH);               // One step per operand bit
          end
        end
        mul_pkg::LANE_CALC: begin
          if (step) begin
            count_q <= count_q - 1'b1;
          end else begin
            state_q <= mul_pkg::LANE_DONE;
            ack_q   <= lane_if_i.req;               // Product valid from here
          end
        end
        mul_pkg::LANE_DONE: begin
          if (lane_if_i.take == ack_q) begin
            state_q <= mul_pkg::LANE_IDLE;          // Collector has it
          end
        end
        default: state_q <= mul_pkg::LANE_IDLE;
      endcase
    end
  end

  always_ff @(posedge sys_clock_i) begin
    if (start) begin
      a_shift_q <= {{WIDTH{1'b0}}, a_mag};
      b_shift_q <= b_mag;
      acc_q     <= '0;
      neg_q     <= a_is_neg ^ b_is_neg;             // Exactly one negative operand
    end else if (step) begin
      acc_q     <= acc_next;
      a_shift_q <= a_shift_q << 1;
      b_shift_q <= b_shift_q >> 1;
    end
    if (finish) begin
      product_q <= neg_q ? (~acc_q + 1'b1) : acc_q; // Restore sign
    end
  end

  assign lane_if_i.ack     = ack_q;
  assign lane_if_i.product = product_q;
  // Free only once all three link levels agree
  assign lane_if_i.free    = (state_q == mul_pkg::LANE_IDLE) &&
                             (lane_if_i.req == ack_q) && (lane_if_i.take == ack_q);

endmodule

/* verilog/mul_collect.sv */
module mul_collect #(
  parameter int WIDTH     = 32,
  parameter int NUM_LANES = 4
) (
  input  logic               sys_clock_i,
  input  logic               sys_reset_i,
  mul_abp_if.drain           lane_if_i [NUM_LANES],   // One link per lane
  output logic               out_req_o,               // Toggles per new product
  input  logic               out_ack_i,               // Consumer answer level
  output logic [2*WIDTH-1:0] product_o                // Held while link pending
);

  localparam int PTR_W = $clog2(NUM_LANES);

  logic [PTR_W-1:0]     ptr_q;                        // Next lane to drain
  logic [NUM_LANES-1:0] take_q;                       // Take level per lane
  logic [NUM_LANES-1:0] lane_ack;                     // Gathered ack levels
  logic [2*WIDTH-1:0]   lane_product [NUM_LANES];     // Gathered products
  logic                 out_idle;                     // External link settled
  logic                 drain;                        // Move one result now

  for (genvar g = 0; g < NUM_LANES; g++) begin : g_lane
    assign lane_ack[g]       = lane_if_i[g].ack;
    assign lane_product[g]   = lane_if_i[g].product;
    assign lane_if_i[g].take = take_q[g];
  end

  assign out_idle = (out_req_o == out_ack_i);
  // Lane at the pointer has an uncollected result
  assign drain    = (lane_ack[ptr_q] != take_q[ptr_q]) && out_idle;

  always_ff @(posedge sys_clock_i) begin
    if (sys_reset_i) begin
      ptr_q     <= '0;
      take_q    <= '0;
      out_req_o <= 1'b0;
      product_o <= '0;
    end else if (drain) begin
      product_o     <= lane_product[ptr_q];           // Copy before confirming
      out_req_o     <= ~out_req_o;                    // Present to consumer
      take_q[ptr_q] <= ~take_q[ptr_q];                // Release the lane
      if (ptr_q == PTR_W'(NUM_LANES - 1)) begin
        ptr_q <= '0;
      end else begin
        ptr_q <= ptr_q + 1'b1;                        // Same order as dispatch
      end
    end
  end

endmodule

/* verilog/mul_cluster.sv */
module mul_cluster #(
  parameter int WIDTH     = 32,
  parameter int NUM_LANES = 4
) (
  input  logic               sys_clock_i,
  input  logic               sys_reset_i,
  input  logic               in_req_i,            // Input ABP request level
  output logic               in_ack_o,            // Input ABP acknowledge
  input  logic [WIDTH-1:0]   a_i,                 // Operand A
  input  logic [WIDTH-1:0]   b_i,                 // Operand B
  input  mul_pkg::mul_op_e   op_i,                // Operation type
  output logic               out_req_o,           // Output ABP request level
  input  logic               out_ack_i,           // Output ABP acknowledge
  output logic [2*WIDTH-1:0] product_o            // Full product
);

  // One link per lane between dispatcher, lane and collector
  mul_abp_if #(.WIDTH(WIDTH)) lane_if [NUM_LANES] ();

  mul_dispatch #(
    .WIDTH     (WIDTH),
    .NUM_LANES (NUM_LANES)
  ) u_dispatch (
    .sys_clock_i (sys_clock_i),
    .sys_reset_i (sys_reset_i),
    .in_req_i    (in_req_i),
    .in_ack_o    (in_ack_o),
    .a_i         (a_i),
    .b_i         (b_i),
    .op_i        (op_i),
    .lane_if_o   (lane_if)
  );

  for (genvar g = 0; g < NUM_LANES; g++) begin : g_lane
    mul_lane #(
      .WIDTH (WIDTH)
    ) u_lane (
      .sys_clock_i (sys_clock_i),
      .sys_reset_i (sys_reset_i),
      .lane_if_i   (lane_if[g])
    );
  end

  mul_collect #(
    .WIDTH     (WIDTH),
    .NUM_LANES (NUM_LANES)
  ) u_collect (
    .sys_clock_i (sys_clock_i),
    .sys_reset_i (sys_reset_i),
    .lane_if_i   (lane_if),
    .out_req_o   (out_req_o),
    .out_ack_i   (out_ack_i),
    .product_o   (product_o)
  );

endmodule

/* bench/tb_mul_cluster.sv */
module tb_mul_cluster;

  localparam int WIDTH       = 32;
  localparam int NUM_RAND    = 40;                        // Random ops per stream
  localparam int NUM_OPS     = 16 + 10 + 2 * NUM_RAND + 3;  // Ops over all tests
  localparam int CYCLE_LIMIT = NUM_OPS * 40 + 200;

  logic               sys_clock_i;
  logic               sys_reset_i;
  logic               in_req_i;
  logic               in_ack_o;
  logic [WIDTH-1:0]   a_i;
  logic [WIDTH-1:0]   b_i;
  mul_pkg::mul_op_e   op_i;
  logic               out_req_o;
  logic               out_ack_i;
  logic [2*WIDTH-1:0] product_o;

  logic [2*WIDTH-1:0] exp_q [$];                          // Expected products, issue order
  logic [WIDTH-1:0]   rand_a [NUM_RAND];
  logic [WIDTH-1:0]   rand_b [NUM_RAND];
  mul_pkg::mul_op_e   rand_op [NUM_RAND];
  logic [WIDTH-1:0]   corner [4];
  integer             seed = 32'ha6f1_7e79;
  int                 delay_max = 0;                      // Consumer answer delay bound
  int                 errors = 0;
  int                 checks = 0;
  int                 received = 0;                       // Products seen on output link
  int                 max_inflight = 0;
  int                 cycle_count = 0;

  mul_cluster u_dut (
    .sys_clock_i (sys_clock_i),
    .sys_reset_i (sys_reset_i),
    .in_req_i    (in_req_i),
    .in_ack_o    (in_ack_o),
    .a_i         (a_i),
    .b_i         (b_i),
    .op_i        (op_i),
    .out_req_o   (out_req_o),
    .out_ack_i   (out_ack_i),
    .product_o   (product_o)
  );

  initial sys_clock_i = 1'b0;
  always #50 sys_clock_i = ~sys_clock_i;                  // Period 100

  always @(posedge sys_clock_i) begin
    cycle_count <= cycle_count + 1;
    if (cycle_count >= CYCLE_LIMIT) begin
      $display("Timeout after %0d cycles, %0d results still missing",
               cycle_count, exp_q.size());
      $display("TEST FAIL");
      $finish;
    end
  end

  // Extend by operation, multiply at double width
  function automatic logic [2*WIDTH-1:0] expected_product(input logic [WIDTH-1:0] a,
                                                          input logic [WIDTH-1:0] b,
                                                          input mul_pkg::mul_op_e op);
    logic [2*WIDTH-1:0] a_ext;
    logic [2*WIDTH-1:0] b_ext;
    a_ext = (op == mul_pkg::MUL_UU) ? {{WIDTH{1'b0}}, a} : {{WIDTH{a[WIDTH-1]}}, a};
    b_ext = (op == mul_pkg::MUL_SS) ? {{WIDTH{b[WIDTH-1]}}, b} : {{WIDTH{1'b0}}, b};
    return a_ext * b_ext;                                 // Low 2*WIDTH bits kept
  endfunction

  task automatic check_value(input logic [2*WIDTH-1:0] got, input logic [2*WIDTH-1:0] exp,
                             input string what);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("Fail at %0t: %s is %h, expected %h", $time, what, got, exp);
    end
  endtask

  // Wait for input link idle, then present one request
  task automatic issue_op(input logic [WIDTH-1:0] a, input logic [WIDTH-1:0] b,
                          input mul_pkg::mul_op_e op);
    @(posedge sys_clock_i);
    while (in_req_i != in_ack_o) @(posedge sys_clock_i);
    // Every queued op is accepted by now and still owed a product
    if (exp_q.size() > max_inflight) begin
      max_inflight = exp_q.size();
    end
    a_i      <= a;
    b_i      <= b;
    op_i     <= op;
    in_req_i <= ~in_req_i;                                // New ABP request
    exp_q.push_back(expected_product(a, b, op));
  endtask

  task automatic wait_drain();
    @(posedge sys_clock_i);
    while (exp_q.size() != 0 || out_req_o != out_ack_i) @(posedge sys_clock_i);
  endtask

  task automatic report_test(input string name, input int err_before);
    $display("Test %s: %s", name, (errors == err_before) ? "passed" : "failed");
  endtask

  // Answers each out_req_o toggle and compares the product
  initial begin : consumer
    int                 wait_n;
    logic [2*WIDTH-1:0] exp_val;
    out_ack_i = 1'b0;
    forever begin
      @(posedge sys_clock_i);
      if (sys_reset_i) begin
        out_ack_i <= 1'b0;                                // Link levels restart at 0
      end else if (out_req_o != out_ack_i) begin
        received++;
        if (exp_q.size() == 0) begin
          errors++;
          $display("Product %h arrived at %0t with no request outstanding", product_o, $time);
        end else begin
          exp_val = exp_q.pop_front();
          check_value(product_o, exp_val, "product");
        end
        wait_n = (delay_max > 0) ? {$random(seed)} % (delay_max + 1) : 0;
        repeat (wait_n) @(posedge sys_clock_i);           // Stalls the collector
        out_ack_i <= out_req_o;
      end
    end
  end

  initial begin : main
    int err_before;
    int rcv_before;
    sys_reset_i = 1'b1;
    in_req_i    = 1'b0;
    a_i         = '0;
    b_i         = '0;
    op_i        = mul_pkg::MUL_UU;
    corner[0]   = 32'h0000_0000;
    corner[1]   = 32'h0000_0001;
    corner[2]   = 32'hffff_ffff;
    corner[3]   = 32'h8000_0000;
    for (int i = 0; i < NUM_RAND; i++) begin              // One stream, reused in test 5
      rand_a[i]  = $random(seed);
      rand_b[i]  = $random(seed);
      rand_op[i] = mul_pkg::mul_op_e'(2'({$random(seed)} % 3));
    end
    repeat (3) @(posedge sys_clock_i);
    sys_reset_i <= 1'b0;

    err_before = errors;
    repeat (2) @(posedge sys_clock_i);
    check_value(in_ack_o, '0, "in_ack_o after reset");
    check_value(out_req_o, '0, "out_req_o after reset");
    report_test("reset state", err_before);

    err_before = errors;
    for (int i = 0; i < 4; i++) begin
      for (int j = 0; j < 4; j++) begin
        issue_op(corner[i], corner[j], mul_pkg::MUL_UU);
      end
    end
    wait_drain();
    report_test("unsigned corners", err_before);

    err_before = errors;
    issue_op(32'hffff_ffff, 32'hffff_ffff, mul_pkg::MUL_SS);  // -1 * -1
    issue_op(-32'd5, 32'd7, mul_pkg::MUL_SS);
    issue_op(32'd7, -32'd5, mul_pkg::MUL_SS);
    issue_op(32'h8000_0000, 32'h8000_0000, mul_pkg::MUL_SS);  // Most negative squared
    issue_op(-32'd3, 32'h8000_0000, mul_pkg::MUL_SS);         // Negative by most negative
    issue_op(32'h7fff_ffff, 32'h8000_0000, mul_pkg::MUL_SS);
    issue_op(32'hffff_ffff, 32'hffff_ffff, mul_pkg::MUL_SU);  // B stays unsigned
    issue_op(32'h8000_0000, 32'hffff_ffff, mul_pkg::MUL_SU);
    issue_op(-32'd7, 32'd3, mul_pkg::MUL_SU);
    issue_op(32'd5, 32'h8000_0000, mul_pkg::MUL_SU);
    wait_drain();
    report_test("signed operands", err_before);

    err_before   = errors;
    max_inflight = 0;
    for (int i = 0; i < NUM_RAND; i++) issue_op(rand_a[i], rand_b[i], rand_op[i]);
    wait_drain();
    if (max_inflight < 2) begin
      errors++;
      $display("Back-to-back stream never had two products in flight");
    end
    report_test("random back to back", err_before);

    err_before = errors;
    delay_max  = 60;                                      // Random 0 to 60 cycle answers
    for (int i = 0; i < NUM_RAND; i++) issue_op(rand_a[i], rand_b[i], rand_op[i]);
    wait_drain();
    delay_max  = 0;
    report_test("random with stalled consumer", err_before);

    err_before = errors;
    issue_op(32'd1234, 32'd5678, mul_pkg::MUL_UU);
    wait_drain();
    issue_op(32'hdead_beef, 32'd3, mul_pkg::MUL_SS);
    repeat (10) @(posedge sys_clock_i);                   // Lane still calculating
    sys_reset_i <= 1'b1;
    in_req_i    <= 1'b0;
    repeat (3) @(posedge sys_clock_i);
    exp_q.delete();                                       // In-flight op dropped by reset
    sys_reset_i <= 1'b0;
    rcv_before  = received;
    repeat (60) @(posedge sys_clock_i);
    if (received != rcv_before) begin
      errors++;
      $display("A product came out after reset with no new request");
    end
    check_value(out_req_o, '0, "out_req_o idle after reset");
    issue_op(32'hffff_fff0, 32'd16, mul_pkg::MUL_SU);
    wait_drain();
    report_test("reset during operation", err_before);

    $display("Tests done: %0d checks, %0d errors", checks, errors);
    if (errors == 0) begin
      $display("TEST PASS");
    end else begin
      $display("TEST FAIL");
    end
    $finish;
  end

endmodule

/* mul_cluster.f */
verilog/mul_pkg.sv
verilog/mul_abp_if.sv
verilog/mul_dispatch.sv
verilog/mul_lane.sv
verilog/mul_collect.sv
verilog/mul_cluster.sv
bench/tb_mul_cluster.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Build and run the multiply cluster testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing -Wno-fatal -f mul_cluster.f \
  --top-module tb_mul_cluster -o tb_mul_cluster
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

./obj_dir/tb_mul_cluster > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if grep -q "TEST FAIL" "$LOG"; then
  exit 1
fi
if ! grep -q "TEST PASS" "$LOG"; then
  echo "Simulation ended without a result line"
  exit 1
fi
exit 0
